/* rtl/jsp_pkg.sv */
// Debug-port serial channel shared definitions
// Sizes, 16550 register constants, FIFO and bus structs
// and the register word union used on both bus data paths

`default_nettype none

package jsp_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////
  localparam int FIFO_DEPTH = 8;          // Entries per FIFO
  localparam int COUNT_W    = 4;          // Holds 0 .. FIFO_DEPTH

  typedef logic [7:0]         byte_t;
  typedef logic [COUNT_W-1:0] count_t;

  ////////////////////////////////////////
  // Register constants
  ////////////////////////////////////////
  localparam byte_t      LCR_8N1        = 8'h03;  // 8 data bits, no parity, 1 stop
  localparam byte_t      MSR_IDLE       = 8'hB0;  // CD, DSR, CTS high, RI low
  localparam logic [2:0] IIR_NONE       = 3'b001;
  localparam logic [2:0] IIR_THRE       = 3'b010; // Transmit holding empty
  localparam logic [2:0] IIR_RDA        = 3'b100; // Receive data available
  localparam int         DLAB_BIT       = 7;
  localparam int         FCR_RX_RST_BIT = 1;
  localparam int         FCR_TX_RST_BIT = 2;

  // One FIFO operation, push or pop when en
  typedef struct packed {
    logic en;
    logic push;                           // 1 push, 0 pop
  } fifo_cmd_t;

  // FIFO occupancy
  typedef struct packed {
    count_t avail;
    count_t free;
  } fifo_stat_t;

  // Wishbone slave request, only address bit 2 is decoded
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic        adr2;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  ////////////////////////////////////////
  // Register words
  ////////////////////////////////////////
  typedef struct packed {
    byte_t fifo;                          // RBR / THR
    byte_t ier;
    byte_t iir_fcr;                       // IIR on read, FCR on write
    byte_t lcr;
  } lo_word_t;

  typedef struct packed {
    byte_t mcr;
    byte_t lsr;
    byte_t msr;
    byte_t scr;
  } hi_word_t;

  // Same bus word, decoded by adr2
  typedef union packed {
    lo_word_t lo;
    hi_word_t hi;
  } bus_word_u;

endpackage

`default_nettype wire

/* rtl/jsp_byte_fifo.sv */
// Byte FIFO for the debug-port channel
// Circular buffer with a shared push/pop enable,
// head output and avail/free occupancy counts

`default_nettype none

module jsp_byte_fifo (
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  wire                 clr_i,      // FCR clear pulse
  input  jsp_pkg::fifo_cmd_t  cmd_i,
  input  jsp_pkg::byte_t      wdata_i,
  output jsp_pkg::byte_t      rdata_o,    // Head entry
  output jsp_pkg::fifo_stat_t stat_o
);

  jsp_pkg::byte_t             mem [jsp_pkg::FIFO_DEPTH];
  logic [jsp_pkg::COUNT_W-2:0] wr_ptr;   // Wraps at FIFO_DEPTH
  logic [jsp_pkg::COUNT_W-2:0] rd_ptr;
  jsp_pkg::count_t            count;
  logic                       full;
  logic                       empty;
  logic                       do_push;
  logic                       do_pop;

  assign full    = (count == jsp_pkg::count_t'(jsp_pkg::FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = cmd_i.en &  cmd_i.push & ~full;  // Push when full is dropped
  assign do_pop  = cmd_i.en & ~cmd_i.push & ~empty; // Pop when empty is ignored

  // Pointers and count, FCR clear acts like reset here
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
      count  <= count + 1'b1;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
      count  <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  assign rdata_o      = mem[rd_ptr];
  assign stat_o.avail = count;
  assign stat_o.free  = jsp_pkg::count_t'(jsp_pkg::FIFO_DEPTH) - count;

endmodule

`default_nettype wire

/* rtl/jsp_rx_path.sv */
// Debug-to-bus receive path
// Latches bytes written by the debug host and interleaves
// their receive FIFO pushes with pops for bus reads

`default_nettype none

module jsp_rx_path (
  input  wire                wb_clk_i,
  input  wire                rst_i,
  input  jsp_pkg::byte_t     data_i,      // Debug write byte
  input  wire                wr_strobe_i,
  input  wire                bus_rd_i,    // FIFO lane read request
  output jsp_pkg::fifo_cmd_t rx_cmd_o,
  output jsp_pkg::byte_t     rx_wdata_o,
  output logic               rd_ack_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PUSH,
    RX_POP
  } rx_state_e;

  rx_state_e      state_q;
  rx_state_e      state_d;
  jsp_pkg::byte_t byte_q;                  // Latched debug byte
  logic           pend_q;                  // Byte waits for a push

  ////////////////////////////////////////
  // Debug write capture
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (wr_strobe_i) begin
      byte_q <= data_i;
    end
  end

  // New strobe wins over the clear in RX_PUSH
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (wr_strobe_i) begin
      pend_q <= 1'b1;
    end else if (state_q == RX_PUSH) begin
      pend_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Push/pop sequencer
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) state_q <= RX_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d = RX_IDLE;
    case (state_q)
      RX_IDLE: begin
        if (bus_rd_i)    state_d = RX_POP;   // Bus read first
        else if (pend_q) state_d = RX_PUSH;
      end
      RX_PUSH: if (bus_rd_i) state_d = RX_POP;
      RX_POP:  if (pend_q)   state_d = RX_PUSH; // Request drops after ack
      default: state_d = RX_IDLE;
    endcase
  end

  // Decoded outputs
  always_comb begin
    rx_cmd_o = '0;
    rd_ack_o = 1'b0;
    case (state_q)
      RX_PUSH: begin
        rx_cmd_o.en   = 1'b1;
        rx_cmd_o.push = 1'b1;
      end
      RX_POP: begin
        rx_cmd_o.en = 1'b1;                 // Head is on the bus this cycle
        rd_ack_o    = 1'b1;
      end
      default: ;
    endcase
  end

  assign rx_wdata_o = byte_q;

endmodule

`default_nettype wire

/* rtl/jsp_tx_path.sv */
// Bus-to-debug transmit path
// Pushes bus bytes into the transmit FIFO, pops bytes the
// debug host has taken and holds the byte shown on data_o

`default_nettype none

module jsp_tx_path (
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  wire                 rd_strobe_i,     // Debug host took data_o
  input  wire                 debug_select_i,  // Low drains the FIFO
  input  wire                 bus_wr_i,        // FIFO lane write request
  input  jsp_pkg::byte_t      bus_byte_i,
  input  jsp_pkg::byte_t      tx_rdata_i,      // FIFO head
  input  jsp_pkg::fifo_stat_t tx_stat_i,
  output jsp_pkg::fifo_cmd_t  tx_cmd_o,
  output jsp_pkg::byte_t      tx_wdata_o,
  output logic                wr_ack_o,
  output jsp_pkg::byte_t      data_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_PUSH,
    TX_POP,
    TX_LATCH
  } tx_state_e;

  tx_state_e      state_q;
  tx_state_e      state_d;
  logic           pop_pend_q;              // Read strobe not yet served
  logic           tx_empty;
  logic           pop_req;
  jsp_pkg::byte_t data_q;

  assign tx_empty = (tx_stat_i.avail == '0);
  assign pop_req  = (pop_pend_q | ~debug_select_i) & ~tx_empty;

  // Read strobe flag
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      pop_pend_q <= 1'b0;
    end else if (rd_strobe_i) begin
      pop_pend_q <= 1'b1;
    end else if (state_q == TX_POP) begin
      pop_pend_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Push/pop/latch sequencer
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) state_q <= TX_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d = TX_IDLE;
    case (state_q)
      TX_IDLE, TX_LATCH: begin
        if (bus_wr_i)     state_d = TX_PUSH;
        else if (pop_req) state_d = TX_POP;
      end
      TX_PUSH: begin
        if (tx_empty)     state_d = TX_LATCH; // First byte becomes the head
        else if (pop_req) state_d = TX_POP;
      end
      TX_POP:  state_d = TX_LATCH;            // New head settles
      default: state_d = TX_IDLE;
    endcase
  end

  always_comb begin
    tx_cmd_o = '0;
    wr_ack_o = 1'b0;
    case (state_q)
      TX_PUSH: begin
        tx_cmd_o.en   = 1'b1;
        tx_cmd_o.push = 1'b1;
        wr_ack_o      = 1'b1;               // Acked even when full
      end
      TX_POP:  tx_cmd_o.en = 1'b1;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Debug output byte
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_q <= '0;
    end else if (state_q == TX_LATCH) begin
      data_q <= tx_rdata_i;
    end
  end

  assign data_o     = data_q;
  assign tx_wdata_o = bus_byte_i;

endmodule

`default_nettype wire

/* rtl/jsp_uart_regs.sv */
// 16550-style register block on the Wishbone slave port
// Decodes FIFO lane and register accesses, keeps DLAB, IER
// and the THRE arm bit, builds read data and the interrupt

`default_nettype none

module jsp_uart_regs (
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  jsp_pkg::wb_req_t    wb_req_i,
  input  jsp_pkg::byte_t      rx_rdata_i,   // Receive FIFO head
  input  jsp_pkg::fifo_stat_t rx_stat_i,
  input  jsp_pkg::fifo_stat_t tx_stat_i,
  input  jsp_pkg::fifo_cmd_t  tx_cmd_i,
  input  wire                 rd_ack_i,
  input  wire                 wr_ack_i,
  output logic                bus_rd_o,
  output logic                bus_wr_o,
  output jsp_pkg::byte_t      bus_byte_o,
  output logic                rx_clr_o,
  output logic                tx_clr_o,
  output jsp_pkg::bus_word_u  wb_dat_o,
  output logic                wb_ack_o,
  output logic                int_o
);

  jsp_pkg::bus_word_u wdata;               // Write data, low register view
  jsp_pkg::lo_word_t  lo_word;
  jsp_pkg::hi_word_t  hi_word;
  logic               access;
  logic               lo_sel;
  logic               fifo_lane;
  logic               reg_ack;
  logic               dlab_q;
  logic [1:0]         ier_q;
  logic               arm_q;               // THRE interrupt armed
  logic               rx_not_empty;
  logic               tx_not_full;
  logic               tx_becoming_empty;
  logic               fcr_wr;
  logic               iir_rd;
  logic [2:0]         iir;

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////
  assign wdata     = wb_req_i.dat;
  assign access    = wb_req_i.cyc & wb_req_i.stb;
  assign lo_sel    = access & ~wb_req_i.adr2;
  assign fifo_lane = ~wb_req_i.adr2 & wb_req_i.sel[3];

  assign bus_rd_o   = access & ~wb_req_i.we & fifo_lane & ~dlab_q;
  assign bus_wr_o   = access &  wb_req_i.we & fifo_lane & ~dlab_q;
  assign bus_byte_o = wdata.lo.fifo;

  // Plain registers ack at once, FIFO lane waits for the path
  assign reg_ack  = access & (|wb_req_i.sel) & (dlab_q | ~fifo_lane);
  assign wb_ack_o = reg_ack | rd_ack_i | wr_ack_i;

  assign fcr_wr   = lo_sel & wb_req_i.we & wb_req_i.sel[1];
  assign iir_rd   = lo_sel & ~wb_req_i.we & wb_req_i.sel[1];
  assign rx_clr_o = fcr_wr & wdata.lo.iir_fcr[jsp_pkg::FCR_RX_RST_BIT];
  assign tx_clr_o = fcr_wr & wdata.lo.iir_fcr[jsp_pkg::FCR_TX_RST_BIT];

  ////////////////////////////////////////
  // LCR, IER, arm bit
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      dlab_q <= 1'b0;
      ier_q  <= '0;
    end else begin
      if (lo_sel & wb_req_i.we & wb_req_i.sel[0])
        dlab_q <= wdata.lo.lcr[jsp_pkg::DLAB_BIT];
      if (lo_sel & wb_req_i.we & wb_req_i.sel[2] & ~dlab_q)
        ier_q <= wdata.lo.ier[1:0];           // Upper IER bits not kept
    end
  end

  assign rx_not_empty      = (rx_stat_i.avail != '0);
  assign tx_not_full       = (tx_stat_i.free != '0);
  // Last byte leaving the transmit FIFO
  assign tx_becoming_empty = tx_cmd_i.en & ~tx_cmd_i.push & (tx_stat_i.avail == 1);

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      arm_q <= 1'b0;
    end else if (bus_wr_o | tx_becoming_empty) begin
      arm_q <= 1'b1;
    end else if (iir_rd & ~rx_not_empty) begin
      arm_q <= 1'b0;                          // IIR read acknowledges THRE
    end
  end

  // IIR priority, receive data first
  always_comb begin
    if (rx_not_empty)              iir = jsp_pkg::IIR_RDA;
    else if (arm_q & tx_not_full)  iir = jsp_pkg::IIR_THRE;
    else                           iir = jsp_pkg::IIR_NONE;
  end

  assign int_o = (rx_not_empty & ier_q[0]) | (arm_q & tx_not_full & ier_q[1]);

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////
  assign lo_word.fifo    = rx_rdata_i;
  assign lo_word.ier     = {6'b0, ier_q};
  assign lo_word.iir_fcr = {5'b0, iir};
  assign lo_word.lcr     = {dlab_q, jsp_pkg::LCR_8N1[6:0]};

  assign hi_word.mcr = '0;                    // No modem lines
  assign hi_word.lsr = {1'b0, tx_not_full, tx_not_full, 4'b0000, rx_not_empty};
  assign hi_word.msr = jsp_pkg::MSR_IDLE;
  assign hi_word.scr = '0;

  always_comb begin
    if (wb_req_i.adr2) wb_dat_o.hi = hi_word;
    else               wb_dat_o.lo = lo_word;
  end

endmodule

`default_nettype wire

/* rtl/jsp_top.sv */
// Debug-port serial channel top level
// 16550-like Wishbone slave in front of two byte FIFOs
// that connect to a debug host byte port

`default_nettype none

module jsp_top (
  input  wire                wb_clk_i,
  input  wire                rst_i,
  // Debug side
  input  jsp_pkg::byte_t     data_i,
  input  wire                wr_strobe_i,
  input  wire                rd_strobe_i,
  input  wire                debug_select_i,
  output jsp_pkg::byte_t     data_o,
  output jsp_pkg::count_t    bytes_free_o,       // Receive FIFO space
  output jsp_pkg::count_t    bytes_available_o,  // Transmit FIFO fill
  // Bus side
  input  jsp_pkg::wb_req_t   wb_req_i,
  output jsp_pkg::bus_word_u wb_dat_o,
  output logic               wb_ack_o,
  output logic               int_o
);

  jsp_pkg::fifo_cmd_t  rx_cmd;
  jsp_pkg::fifo_cmd_t  tx_cmd;
  jsp_pkg::byte_t      rx_wdata;
  jsp_pkg::byte_t      tx_wdata;
  jsp_pkg::byte_t      rx_rdata;
  jsp_pkg::byte_t      tx_rdata;
  jsp_pkg::fifo_stat_t rx_stat;
  jsp_pkg::fifo_stat_t tx_stat;
  jsp_pkg::byte_t      bus_byte;
  logic                bus_rd;
  logic                bus_wr;
  logic                rd_ack;
  logic                wr_ack;
  logic                rx_clr;
  logic                tx_clr;

  ////////////////////////////////////////
  // Receive side, debug to bus
  ////////////////////////////////////////
  jsp_rx_path rx_path_i (
    .wb_clk_i, .rst_i, .data_i, .wr_strobe_i,
    .bus_rd_i(bus_rd), .rx_cmd_o(rx_cmd), .rx_wdata_o(rx_wdata), .rd_ack_o(rd_ack)
  );

  jsp_byte_fifo rx_fifo (
    .wb_clk_i, .rst_i, .clr_i(rx_clr), .cmd_i(rx_cmd), .wdata_i(rx_wdata),
    .rdata_o(rx_rdata), .stat_o(rx_stat)
  );

  // Transmit side, bus to debug
  jsp_tx_path tx_path_i (
    .wb_clk_i, .rst_i, .rd_strobe_i, .debug_select_i,
    .bus_wr_i(bus_wr), .bus_byte_i(bus_byte), .tx_rdata_i(tx_rdata), .tx_stat_i(tx_stat),
    .tx_cmd_o(tx_cmd), .tx_wdata_o(tx_wdata), .wr_ack_o(wr_ack), .data_o
  );

  jsp_byte_fifo tx_fifo (
    .wb_clk_i, .rst_i, .clr_i(tx_clr), .cmd_i(tx_cmd), .wdata_i(tx_wdata),
    .rdata_o(tx_rdata), .stat_o(tx_stat)
  );

  // Register block
  jsp_uart_regs regs_i (
    .wb_clk_i, .rst_i, .wb_req_i,
    .rx_rdata_i(rx_rdata), .rx_stat_i(rx_stat), .tx_stat_i(tx_stat), .tx_cmd_i(tx_cmd),
    .rd_ack_i(rd_ack), .wr_ack_i(wr_ack),
    .bus_rd_o(bus_rd), .bus_wr_o(bus_wr), .bus_byte_o(bus_byte),
    .rx_clr_o(rx_clr), .tx_clr_o(tx_clr), .wb_dat_o, .wb_ack_o, .int_o
  );

  assign bytes_free_o      = rx_stat.free;
  assign bytes_available_o = tx_stat.avail;

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock, reset held high for the first 4 cycles

`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;           // Half period
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;                        // Released on a rising edge
  end

endmodule

`default_nettype wire

/* tests/tb_jsp_top.sv */
// Testbench for the debug-port serial channel
// Drives the debug byte port and the Wishbone slave, keeps a
// reference model of both FIFOs and the registers, and compares

`default_nettype none

module tb_jsp_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic               wb_clk_i;
  logic               rst_i;
  jsp_pkg::byte_t     data_i;
  logic               wr_strobe_i;
  logic               rd_strobe_i;
  logic               debug_select_i;
  jsp_pkg::byte_t     data_o;
  jsp_pkg::count_t    bytes_free_o;
  jsp_pkg::count_t    bytes_available_o;
  jsp_pkg::wb_req_t   wb_req_i;
  jsp_pkg::bus_word_u wb_dat_o;
  logic               wb_ack_o;
  logic               int_o;

  // Reference model state
  jsp_pkg::byte_t rx_q[$];                  // Debug to bus
  jsp_pkg::byte_t tx_q[$];                  // Bus to debug
  logic           m_dlab = 1'b0;
  logic [1:0]     m_ier = 2'b00;
  logic           m_arm = 1'b0;             // THRE armed
  integer         seed = 32'h6fb7dd03;
  int             cycles = 0;
  int             n_checks = 0;
  int             n_errors = 0;
  int             test_err0 = 0;
  string          test_name = "none";
  event           status_ev;                // Outputs settled, compare now

  tb_clock_gen clk_gen_i (.clk_o(wb_clk_i), .rst_o(rst_i));

  jsp_top dut_i (
    .wb_clk_i, .rst_i, .data_i, .wr_strobe_i, .rd_strobe_i, .debug_select_i,
    .data_o, .bytes_free_o, .bytes_available_o,
    .wb_req_i, .wb_dat_o, .wb_ack_o, .int_o
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic jsp_pkg::bus_word_u ref_expect(input logic adr2);
    jsp_pkg::bus_word_u w;
    logic               rx_ne;
    logic               tx_nf;
    logic [2:0]         iir;
    rx_ne = (rx_q.size() != 0);
    tx_nf = (tx_q.size() < 8);
    if (rx_ne)               iir = 3'b100;  // RDA first
    else if (m_arm && tx_nf) iir = 3'b010;  // THRE
    else                     iir = 3'b001;
    if (adr2) begin
      w.hi.mcr = 8'h00;
      w.hi.lsr = {1'b0, tx_nf, tx_nf, 4'b0000, rx_ne};
      w.hi.msr = 8'hB0;
      w.hi.scr = 8'h00;
    end else begin
      w.lo.fifo    = rx_ne ? rx_q[0] : 8'h00;
      w.lo.ier     = {6'b0, m_ier};
      w.lo.iir_fcr = {5'b0, iir};
      w.lo.lcr     = {m_dlab, 7'h03};     // 8N1 below DLAB
    end
    return w;
  endfunction

  function automatic logic expected_int();
    return (rx_q.size() != 0 && m_ier[0]) || (m_arm && tx_q.size() < 8 && m_ier[1]);
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_byte(input string what, input jsp_pkg::byte_t exp,
                            input jsp_pkg::byte_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Only the byte lanes in sel are compared
  task automatic check_word(input string what, input jsp_pkg::bus_word_u exp,
                            input jsp_pkg::bus_word_u act, input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    n_checks++;
    if ((act & mask) !== (exp & mask)) begin
      n_errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what,
               exp & mask, act & mask);
    end
  endtask

  task automatic check_count(input string what, input jsp_pkg::count_t exp,
                             input jsp_pkg::count_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Status outputs against the model after each settle
  always @(status_ev) begin
    check_count("bytes_free_o", jsp_pkg::count_t'(8 - rx_q.size()), bytes_free_o);
    check_count("bytes_available_o", jsp_pkg::count_t'(tx_q.size()), bytes_available_o);
    check_bit("int_o", expected_int(), int_o);
    if (tx_q.size() != 0) check_byte("data_o", tx_q[0], data_o);   // Head only
  end

  // Run limit, several times the length of all tests
  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("timeout: the run did not finish within 3000 cycles");
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////
  task automatic settle_check();
    repeat (4) @(posedge wb_clk_i);         // Idle cycles
    @(negedge wb_clk_i);
    -> status_ev;
    @(posedge wb_clk_i);
  endtask

  // One Wishbone access, held until ack
  task automatic bus_cycle(input logic we, input logic adr2, input logic [3:0] sel,
                           input logic [31:0] dat, output jsp_pkg::bus_word_u rdata);
    jsp_pkg::wb_req_t req;
    int               wait_n;
    req.cyc  = 1'b1;
    req.stb  = 1'b1;
    req.we   = we;
    req.adr2 = adr2;
    req.sel  = sel;
    req.dat  = dat;
    wait_n   = 0;
    @(posedge wb_clk_i);
    wb_req_i <= req;
    @(negedge wb_clk_i);
    while (!wb_ack_o && wait_n < 8) begin
      wait_n++;
      @(negedge wb_clk_i);
    end
    if (!wb_ack_o) begin
      n_errors++;
      $display("%s: bus access got no acknowledge within 8 cycles", test_name);
    end
    rdata = wb_dat_o;
    @(posedge wb_clk_i);
    wb_req_i <= '0;                         // Drop stb after ack
  endtask

  task automatic debug_write(input jsp_pkg::byte_t b);
    @(posedge wb_clk_i);
    data_i      <= b;
    wr_strobe_i <= 1'b1;
    @(posedge wb_clk_i);
    wr_strobe_i <= 1'b0;
    if (rx_q.size() < 8) rx_q.push_back(b); // Full FIFO drops it
    settle_check();
  endtask

  // Debug host takes data_o, only called with data present
  task automatic debug_read();
    @(posedge wb_clk_i);
    rd_strobe_i <= 1'b1;
    @(posedge wb_clk_i);
    rd_strobe_i <= 1'b0;
    void'(tx_q.pop_front());
    if (tx_q.size() == 0) m_arm = 1'b1;     // Becoming empty
    settle_check();
  endtask

  task automatic fifo_write(input jsp_pkg::byte_t b);
    jsp_pkg::bus_word_u rd;
    bus_cycle(1'b1, 1'b0, 4'b1000, {b, 24'h0}, rd);
    if (!m_dlab) begin
      if (tx_q.size() < 8) tx_q.push_back(b);
      m_arm = 1'b1;
    end
    settle_check();
  endtask

  task automatic fifo_read();
    jsp_pkg::bus_word_u rd;
    jsp_pkg::byte_t     exp;
    exp = rx_q.pop_front();
    bus_cycle(1'b0, 1'b0, 4'b1000, 32'h0, rd);
    check_byte("fifo lane", exp, rd.lo.fifo);
    settle_check();
  endtask

  // Low register word writes: LCR, FCR, IER
  task automatic reg_write(input logic [3:0] sel, input logic [31:0] dat);
    jsp_pkg::bus_word_u rd;
    bus_cycle(1'b1, 1'b0, sel, dat, rd);
    if (sel[2] && !m_dlab) m_ier = dat[17:16];   // Old DLAB applies
    if (sel[1] && dat[9])  rx_q.delete();
    if (sel[1] && dat[10]) tx_q.delete();
    if (sel[0])            m_dlab = dat[7];
    settle_check();
  endtask

  task automatic reg_read(input logic adr2, input logic [3:0] sel, input string what);
    jsp_pkg::bus_word_u exp;
    jsp_pkg::bus_word_u rd;
    exp = ref_expect(adr2);
    bus_cycle(1'b0, adr2, sel, 32'h0, rd);
    check_word(what, exp, rd, sel);
    if (!adr2 && sel[1] && rx_q.size() == 0) m_arm = 1'b0;  // IIR read
    settle_check();
  endtask

  // Let the FIFO empty by itself with debug_select_i low
  task automatic drain_tx();
    @(posedge wb_clk_i);
    debug_select_i <= 1'b0;
    @(negedge wb_clk_i);
    while (bytes_available_o != 0) @(negedge wb_clk_i);
    @(posedge wb_clk_i);
    debug_select_i <= 1'b1;
    if (tx_q.size() != 0) m_arm = 1'b1;
    tx_q.delete();
    settle_check();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = n_errors;
  endtask

  task automatic finish_test();
    $display("test %-14s %s", test_name, (n_errors == test_err0) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    int i;
    data_i         = '0;
    wr_strobe_i    = 1'b0;
    rd_strobe_i    = 1'b0;
    debug_select_i = 1'b1;
    wb_req_i       = '0;
    @(negedge rst_i);

    start_test("reset");
    settle_check();
    reg_read(1'b0, 4'b0010, "IIR");
    reg_read(1'b1, 4'b0100, "LSR");
    reg_read(1'b0, 4'b0001, "LCR");
    reg_read(1'b1, 4'b0010, "MSR");
    finish_test();

    start_test("debug_to_bus");
    for (i = 0; i < 9; i++) debug_write(jsp_pkg::byte_t'($random(seed)));  // Ninth dropped
    while (rx_q.size() != 0) begin
      reg_read(1'b1, 4'b0100, "LSR");
      reg_read(1'b0, 4'b0010, "IIR");
      fifo_read();
    end
    reg_read(1'b1, 4'b0100, "LSR");
    finish_test();

    start_test("bus_to_debug");
    for (i = 0; i < 9; i++) begin
      fifo_write(jsp_pkg::byte_t'($random(seed)));
      reg_read(1'b1, 4'b0100, "LSR");       // Bits 5, 6 clear when full
    end
    for (i = 0; i < 3; i++) debug_read();
    reg_read(1'b1, 4'b0100, "LSR");
    drain_tx();
    finish_test();

    start_test("dlab");
    reg_write(4'b0001, 32'h0000_0083);
    reg_read(1'b0, 4'b0001, "LCR");
    fifo_write(8'h5A);                      // Acked, not stored
    reg_write(4'b0100, 32'h0003_0000);      // Ignored
    reg_read(1'b0, 4'b0100, "IER");
    reg_write(4'b0001, 32'h0000_0003);
    reg_read(1'b0, 4'b0001, "LCR");
    finish_test();

    start_test("interrupts");
    reg_write(4'b0100, 32'h0001_0000);      // Receive interrupt only
    debug_write(jsp_pkg::byte_t'($random(seed)));
    reg_read(1'b0, 4'b0010, "IIR");
    fifo_read();
    reg_write(4'b0100, 32'h0002_0000);      // THRE interrupt only
    reg_read(1'b0, 4'b0010, "IIR");         // Disarms
    fifo_write(jsp_pkg::byte_t'($random(seed)));
    drain_tx();
    reg_read(1'b0, 4'b0010, "IIR");
    reg_write(4'b0100, 32'h0000_0000);
    finish_test();

    start_test("fcr_reset");
    for (i = 0; i < 3; i++) begin
      debug_write(jsp_pkg::byte_t'($random(seed)));
      fifo_write(jsp_pkg::byte_t'($random(seed)));
    end
    reg_write(4'b0010, 32'h0000_0200);      // Receive FIFO reset
    reg_read(1'b1, 4'b0100, "LSR");
    reg_write(4'b0010, 32'h0000_0400);      // Transmit FIFO reset
    reg_read(1'b1, 4'b0100, "LSR");
    finish_test();

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/jsp_pkg.sv
rtl/jsp_byte_fifo.sv
rtl/jsp_rx_path.sv
rtl/jsp_tx_path.sv
rtl/jsp_uart_regs.sv
rtl/jsp_top.sv
tests/tb_clock_gen.sv
tests/tb_jsp_top.sv
